// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = fetch_tb
FILELIST = build.f
OBJ_DIR = obj_dir
PASS_TEXT = PASS: all tests

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+logic
logic/isa_pkg.sv
logic/fetch_ctrl_pkg.sv
logic/instr_mem.sv
logic/pc_sequencer.sv
logic/load_hazard_check.sv
logic/fetch_issue.sv
logic/fetch_top.sv
test/fetch_props.sv
test/fetch_tb.sv

// ==== logic/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Instruction store holds 2**IMEM_AW words.
`define IMEM_AW 6

`define RESET_PC 32'h0000_001F
`define INT_VECTOR 32'h0000_0000

// Held cycles of each control flow sequence.
`define INT_CYCLES 5
`define RTI_CYCLES 6
`define CALL_CYCLES 4
`define SEQ_CNT_W 3

`endif

// ==== logic/fetch_ctrl_pkg.sv ====
package fetch_ctrl_pkg;

	// Encoding follows the processor's state type field.
	typedef enum logic [2:0] {
		SEQ_RUN = 3'd0,
		SEQ_INT = 3'd1,
		SEQ_RTI = 3'd2,
		SEQ_CALL = 3'd3
	} seq_state_t;

	// PC replacement during a held sequence.
	typedef struct packed {
		logic load;
		logic half;
		logic hi;
		logic [31:0] pc;
	} redirect_t;

	// Instruction store write port.
	typedef struct packed {
		logic en;
		logic [31:0] addr;
		logic [15:0] data;
	} mem_wr_t;

endpackage

// ==== logic/fetch_issue.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_issue (
	input logic clk,
	input logic rst,
	input logic fetch_en,
	input logic [31:0] cand_pc,
	input isa_pkg::instr_w cand_word,
	input logic stall,
	input fetch_ctrl_pkg::redirect_t redir,
	input logic int_entry,
	output logic [31:0] pc,
	output isa_pkg::instr_w instr,
	output logic instr_valid,
	output isa_pkg::opcode_t issued_op,
	output logic issued_now
);

	logic bubble;

	assign bubble = int_entry | stall;
	assign issued_now = fetch_en & ~bubble;
	assign issued_op = cand_word.reg_form.opcode;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			instr <= '0;
			instr_valid <= 1'b0;
		end else if (redir.load) begin
			// Halfword loads come from the RTI sequence.
			if (!redir.half) begin
				pc <= redir.pc;
			end else if (redir.hi) begin
				pc[31:16] <= redir.pc[31:16];
			end else begin
				pc[15:0] <= redir.pc[15:0];
			end
		end else if (fetch_en) begin
			if (bubble) begin
				instr <= '0;
				instr_valid <= 1'b0;
			end else begin
				pc <= cand_pc;
				instr <= cand_word;
				instr_valid <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top (
	input logic clk,
	input logic rst,
	input fetch_ctrl_pkg::mem_wr_t mem_wr,
	input logic jump_taken,
	input logic [15:0] jump_target,
	input logic direct_jump,
	input logic [15:0] direct_target,
	input logic interrupt,
	input logic [15:0] data_bus,
	input logic [15:0] call_target,
	output logic [31:0] pc,
	output isa_pkg::instr_w instr,
	output logic instr_valid,
	output logic busy
);

	logic fetch_en;
	logic [31:0] cand_pc;
	isa_pkg::instr_w cand_word;
	logic stall;
	fetch_ctrl_pkg::redirect_t redir;
	logic int_entry;
	isa_pkg::opcode_t issued_op;
	logic issued_now;

	// Writes and sequences both hold the stage.
	assign fetch_en = ~mem_wr.en & ~busy;

	instr_mem u_mem (
		.clk (clk),
		.wr (mem_wr),
		.raddr (cand_pc[`IMEM_AW-1:0]),
		.rdata (cand_word)
	);

	pc_sequencer u_seq (
		.clk (clk),
		.rst (rst),
		.fetch_en (fetch_en),
		.pc (pc),
		.issued_op (issued_op),
		.issued_now (issued_now),
		.interrupt (interrupt),
		.jump_taken (jump_taken),
		.jump_target (jump_target),
		.direct_jump (direct_jump),
		.direct_target (direct_target),
		.data_bus (data_bus),
		.call_target (call_target),
		.cand_pc (cand_pc),
		.redir (redir),
		.int_entry (int_entry),
		.busy (busy)
	);

	load_hazard_check u_hazard (
		.prev (instr),
		.cand (cand_word),
		.stall (stall)
	);

	fetch_issue u_issue (
		.clk (clk),
		.rst (rst),
		.fetch_en (fetch_en),
		.cand_pc (cand_pc),
		.cand_word (cand_word),
		.stall (stall),
		.redir (redir),
		.int_entry (int_entry),
		.pc (pc),
		.instr (instr),
		.instr_valid (instr_valid),
		.issued_op (issued_op),
		.issued_now (issued_now)
	);

endmodule

// ==== logic/instr_mem.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module instr_mem (
	input logic clk,
	input fetch_ctrl_pkg::mem_wr_t wr,
	input logic [`IMEM_AW-1:0] raddr,
	output isa_pkg::instr_w rdata
);

	localparam int DEPTH = 1 << `IMEM_AW;

	isa_pkg::instr_w mem [DEPTH];
	logic [`IMEM_AW-1:0] waddr;

	// Only the low address bits select a word.
	assign waddr = wr.addr[`IMEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[waddr] <= wr.data;
		end
	end

	// Candidate word is needed in the same cycle.
	assign rdata = mem[raddr];

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

	// Opcode sits in the top five bits of every word.
	typedef logic [4:0] opcode_t;

	localparam opcode_t OP_LDX = 5'd9;
	localparam opcode_t OP_LD = 5'd10;
	localparam opcode_t OP_CALL = 5'd20;
	localparam opcode_t OP_RTI = 5'd22;

	// Register form with two register fields and a short tail.
	typedef struct packed {
		opcode_t opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] tail;
	} reg_form_t;

	// Wide form with an opcode and an 11 bit immediate.
	typedef struct packed {
		opcode_t opcode;
		logic [10:0] imm;
	} wide_form_t;

	// The same 16 bits read in either form.
	typedef union packed {
		reg_form_t reg_form;
		wide_form_t wide_form;
	} instr_w;

endpackage

// ==== logic/load_hazard_check.sv ====
`timescale 1ns/1ps

module load_hazard_check (
	input isa_pkg::instr_w prev,
	input isa_pkg::instr_w cand,
	output logic stall
);

	isa_pkg::opcode_t prev_op;
	logic [2:0] ld_dst;
	logic [2:0] ldx_dst;
	logic ld_hit;
	logic ldx_hit;

	assign prev_op = prev.reg_form.opcode;

	// LD writes rd, LDX writes rs.
	assign ld_dst = prev.reg_form.rd;
	assign ldx_dst = prev.reg_form.rs;

	always_comb begin
		ld_hit = 1'b0;
		ldx_hit = 1'b0;
		if (prev_op == isa_pkg::OP_LD) begin
			ld_hit = (ld_dst == cand.reg_form.rs) || (ld_dst == cand.reg_form.rd);
		end
		if (prev_op == isa_pkg::OP_LDX) begin
			ldx_hit = (ldx_dst == cand.reg_form.rs) || (ldx_dst == cand.reg_form.rd);
		end
	end

	// A zero bubble never matches either opcode.
	assign stall = ld_hit | ldx_hit;

endmodule

// ==== logic/pc_sequencer.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pc_sequencer (
	input logic clk,
	input logic rst,
	input logic fetch_en,
	input logic [31:0] pc,
	input isa_pkg::opcode_t issued_op,
	input logic issued_now,
	input logic interrupt,
	input logic jump_taken,
	input logic [15:0] jump_target,
	input logic direct_jump,
	input logic [15:0] direct_target,
	input logic [15:0] data_bus,
	input logic [15:0] call_target,
	output logic [31:0] cand_pc,
	output fetch_ctrl_pkg::redirect_t redir,
	output logic int_entry,
	output logic busy
);

	localparam logic [`SEQ_CNT_W-1:0] INT_LEN = `INT_CYCLES;
	localparam logic [`SEQ_CNT_W-1:0] RTI_LEN = `RTI_CYCLES;
	localparam logic [`SEQ_CNT_W-1:0] CALL_LEN = `CALL_CYCLES;

	// Count values at which the PC is rewritten.
	localparam logic [`SEQ_CNT_W-1:0] RTI_LO_AT = 2;
	localparam logic [`SEQ_CNT_W-1:0] RTI_HI_AT = 1;
	localparam logic [`SEQ_CNT_W-1:0] CALL_AT = 3;

	fetch_ctrl_pkg::seq_state_t state;
	logic [`SEQ_CNT_W-1:0] count;

	assign busy = count != '0;
	assign int_entry = fetch_en & interrupt & (state == fetch_ctrl_pkg::SEQ_RUN);

	// Vector wins once interrupt entry has run out.
	always_comb begin
		if (state == fetch_ctrl_pkg::SEQ_INT) begin
			cand_pc = `INT_VECTOR;
		end else if (jump_taken) begin
			cand_pc = {16'h0000, jump_target};
		end else if (direct_jump) begin
			cand_pc = {16'h0000, direct_target};
		end else begin
			cand_pc = pc + 32'd1;
		end
	end

	always_comb begin
		redir = '0;
		if (state == fetch_ctrl_pkg::SEQ_RTI) begin
			redir.pc = {data_bus, data_bus};
			if (count == RTI_LO_AT) begin
				redir.load = 1'b1;
				redir.half = 1'b1;
			end else if (count == RTI_HI_AT) begin
				redir.load = 1'b1;
				redir.half = 1'b1;
				redir.hi = 1'b1;
			end
		end else if (state == fetch_ctrl_pkg::SEQ_CALL && count == CALL_AT) begin
			redir.load = 1'b1;
			redir.pc = {16'h0000, call_target};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_ctrl_pkg::SEQ_RUN;
			count <= '0;
		end else if (busy) begin
			count <= count - 1'b1;
			// Interrupt state waits for the vector fetch.
			if (count == 1 && state != fetch_ctrl_pkg::SEQ_INT) begin
				state <= fetch_ctrl_pkg::SEQ_RUN;
			end
		end else if (int_entry) begin
			state <= fetch_ctrl_pkg::SEQ_INT;
			count <= INT_LEN;
		end else if (issued_now) begin
			if (issued_op == isa_pkg::OP_RTI) begin
				state <= fetch_ctrl_pkg::SEQ_RTI;
				count <= RTI_LEN;
			end else if (issued_op == isa_pkg::OP_CALL) begin
				state <= fetch_ctrl_pkg::SEQ_CALL;
				count <= CALL_LEN;
			end else begin
				state <= fetch_ctrl_pkg::SEQ_RUN;
			end
		end
	end

endmodule

// ==== test/fetch_props.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_props (
	input logic clk,
	input logic rst,
	input logic fetch_en,
	input logic stall,
	input logic int_entry,
	input fetch_ctrl_pkg::redirect_t redir,
	input logic [31:0] pc,
	input isa_pkg::instr_w instr,
	input logic instr_valid
);

	// Issue registers after a reset cycle.
	reset_values: assert property (@(posedge clk)
		rst |=> pc == `RESET_PC && instr == '0 && !instr_valid)
		else $error("issue registers not at reset values after rst");

	// A hazard or interrupt entry in a fetch cycle leaves a zero bubble.
	bubble_issued: assert property (@(posedge clk) disable iff (rst)
		fetch_en && !redir.load && (stall || int_entry) |=> !instr_valid && instr == '0)
		else $error("bubble not issued on stall or interrupt entry");

	// Held cycles keep the PC unless a redirect count rewrites it.
	pc_held: assert property (@(posedge clk) disable iff (rst)
		!fetch_en && !redir.load |=> $stable(pc))
		else $error("pc changed during a hold without a redirect");

endmodule

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

	localparam int DEPTH = 1 << `IMEM_AW;
	localparam int SEQ_LEN = 200;
	localparam int JUMP_LEN = 400;
	localparam int CASE_CYCLES = 90;
	// Reset, program load, two random phases and eight directed cases.
	localparam int TEST_CYCLES = 16 + DEPTH + SEQ_LEN + JUMP_LEN + 8 * CASE_CYCLES;
	localparam fetch_ctrl_pkg::mem_wr_t NO_WR = '0;

	typedef struct packed {
		logic jump_taken;
		logic [15:0] jump_target;
		logic direct_jump;
		logic [15:0] direct_target;
		logic interrupt;
		logic [15:0] data_bus;
		logic [15:0] call_target;
	} ctl_t;

	logic clk;
	logic rst;
	fetch_ctrl_pkg::mem_wr_t mem_wr;
	logic jump_taken;
	logic [15:0] jump_target;
	logic direct_jump;
	logic [15:0] direct_target;
	logic interrupt;
	logic [15:0] data_bus;
	logic [15:0] call_target;
	logic [31:0] pc;
	isa_pkg::instr_w instr;
	logic instr_valid;
	logic busy;

	// Reference model state.
	logic [15:0] m_mem [DEPTH];
	logic [31:0] m_pc;
	logic [15:0] m_instr;
	logic m_valid;
	fetch_ctrl_pkg::seq_state_t m_state;
	int m_count;
	logic [15:0] lfsr;
	int errors;

	fetch_top DUT (
		.clk (clk),
		.rst (rst),
		.mem_wr (mem_wr),
		.jump_taken (jump_taken),
		.jump_target (jump_target),
		.direct_jump (direct_jump),
		.direct_target (direct_target),
		.interrupt (interrupt),
		.data_bus (data_bus),
		.call_target (call_target),
		.pc (pc),
		.instr (instr),
		.instr_valid (instr_valid),
		.busy (busy)
	);

	bind fetch_issue fetch_props u_props (
		.clk (clk),
		.rst (rst),
		.fetch_en (fetch_en),
		.stall (stall),
		.int_entry (int_entry),
		.redir (redir),
		.pc (pc),
		.instr (instr),
		.instr_valid (instr_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic ctl_t idle_ctl();
		ctl_t c;
		c = '0;
		c.data_bus = 16'(take_bits(16));
		c.call_target = 16'(take_bits(16));
		return c;
	endfunction

	function automatic logic hazard(input logic [15:0] prev, input logic [15:0] cand);
		if (prev[15:11] == isa_pkg::OP_LD) begin
			return prev[7:5] == cand[10:8] || prev[7:5] == cand[7:5];
		end
		if (prev[15:11] == isa_pkg::OP_LDX) begin
			return prev[10:8] == cand[10:8] || prev[10:8] == cand[7:5];
		end
		return 1'b0;
	endfunction

	task automatic stop_on_error();
		errors++;
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_outputs();
		compare("pc", pc, m_pc);
		compare("instr", 32'(instr), 32'(m_instr));
		compare("instr_valid", 32'(instr_valid), 32'(m_valid));
		compare("busy", 32'(busy), 32'(m_count != 0));
	endtask

	// One clock of the reference model for the given inputs.
	task automatic model_step(input fetch_ctrl_pkg::mem_wr_t w, input ctl_t c);
		logic fetch;
		logic int_e;
		logic bubble;
		logic [31:0] cand;
		logic [15:0] word;
		fetch = !w.en && m_count == 0;
		int_e = fetch && c.interrupt && m_state == fetch_ctrl_pkg::SEQ_RUN;
		if (m_state == fetch_ctrl_pkg::SEQ_INT) cand = `INT_VECTOR;
		else if (c.jump_taken) cand = {16'h0000, c.jump_target};
		else if (c.direct_jump) cand = {16'h0000, c.direct_target};
		else cand = m_pc + 32'd1;
		word = m_mem[cand[`IMEM_AW-1:0]];
		bubble = int_e || hazard(m_instr, word);
		if (m_state == fetch_ctrl_pkg::SEQ_RTI && m_count == 2) begin
			m_pc[15:0] = c.data_bus;
		end else if (m_state == fetch_ctrl_pkg::SEQ_RTI && m_count == 1) begin
			m_pc[31:16] = c.data_bus;
		end else if (m_state == fetch_ctrl_pkg::SEQ_CALL && m_count == 3) begin
			m_pc = {16'h0000, c.call_target};
		end else if (fetch && bubble) begin
			m_instr = '0;
			m_valid = 1'b0;
		end else if (fetch) begin
			m_pc = cand;
			m_instr = word;
			m_valid = 1'b1;
		end
		if (m_count != 0) begin
			if (m_count == 1 && m_state != fetch_ctrl_pkg::SEQ_INT) begin
				m_state = fetch_ctrl_pkg::SEQ_RUN;
			end
			m_count = m_count - 1;
		end else if (int_e) begin
			m_state = fetch_ctrl_pkg::SEQ_INT;
			m_count = `INT_CYCLES;
		end else if (fetch && !bubble) begin
			m_state = fetch_ctrl_pkg::SEQ_RUN;
			if (word[15:11] == isa_pkg::OP_RTI) begin
				m_state = fetch_ctrl_pkg::SEQ_RTI;
				m_count = `RTI_CYCLES;
			end else if (word[15:11] == isa_pkg::OP_CALL) begin
				m_state = fetch_ctrl_pkg::SEQ_CALL;
				m_count = `CALL_CYCLES;
			end
		end
		if (w.en) m_mem[w.addr[`IMEM_AW-1:0]] = w.data;
	endtask

	task automatic apply(input fetch_ctrl_pkg::mem_wr_t w, input ctl_t c);
		mem_wr = w;
		jump_taken = c.jump_taken;
		jump_target = c.jump_target;
		direct_jump = c.direct_jump;
		direct_target = c.direct_target;
		interrupt = c.interrupt;
		data_bus = c.data_bus;
		call_target = c.call_target;
	endtask

	// Called 1 ns after a rising edge; returns 1 ns after the next one.
	task automatic cycle(input fetch_ctrl_pkg::mem_wr_t w, input ctl_t c);
		apply(w, c);
		model_step(w, c);
		@(posedge clk);
		#1;
		check_outputs();
	endtask

	task automatic write_word(input logic [`IMEM_AW-1:0] at, input logic [15:0] data);
		fetch_ctrl_pkg::mem_wr_t w;
		w.en = 1'b1;
		w.addr = take_bits(32);
		w.addr[`IMEM_AW-1:0] = at;
		w.data = data;
		cycle(w, idle_ctl());
	endtask

	// Plain fetching with no pending load that could stall a jump.
	task automatic wait_idle();
		int n;
		n = 0;
		while (m_count != 0 || m_state == fetch_ctrl_pkg::SEQ_INT ||
				m_instr[15:11] == isa_pkg::OP_LD || m_instr[15:11] == isa_pkg::OP_LDX) begin
			if (n == 64) begin
				$display("Error: the fetch stage did not return to plain fetching");
				stop_on_error();
			end
			cycle(NO_WR, idle_ctl());
			n++;
		end
	endtask

	task automatic enter_at(input logic [`IMEM_AW-1:0] at, input logic [15:0] word);
		ctl_t c;
		wait_idle();
		write_word(at, word);
		c = idle_ctl();
		c.jump_taken = 1'b1;
		c.jump_target = 16'(at);
		cycle(NO_WR, c);
	endtask

	task automatic hazard_case(input logic [`IMEM_AW-1:0] at, input logic [15:0] load_word,
			input logic [15:0] use_word);
		write_word(at + 1'b1, use_word);
		enter_at(at, load_word);
		compare("instr", 32'(instr), 32'(load_word));
		cycle(NO_WR, idle_ctl());
		compare("instr", 32'(instr), 32'h0);
		compare("instr_valid", 32'(instr_valid), 32'h0);
		compare("pc", pc, 32'(at));
		cycle(NO_WR, idle_ctl());
		compare("instr", 32'(instr), 32'(use_word));
		compare("pc", pc, 32'(at) + 32'd1);
	endtask

	task automatic call_case(input logic [`IMEM_AW-1:0] at);
		ctl_t c;
		logic [15:0] target;
		int n;
		target = 16'(take_bits(16));
		enter_at(at, {isa_pkg::OP_CALL, 11'h000});
		n = 0;
		while (busy) begin
			if (n > 2 * `CALL_CYCLES) begin
				$display("Error: busy never dropped after CALL");
				stop_on_error();
			end
			c = idle_ctl();
			// Busy cycle n runs at count CALL_CYCLES - n.
			if (n == `CALL_CYCLES - 3) c.call_target = target;
			cycle(NO_WR, c);
			n++;
		end
		compare("call busy cycles", n, `CALL_CYCLES);
		compare("pc", pc, {16'h0000, target});
	endtask

	task automatic rti_case(input logic [`IMEM_AW-1:0] at);
		ctl_t c;
		logic [15:0] lo;
		logic [15:0] hi;
		int n;
		lo = 16'(take_bits(16));
		hi = 16'(take_bits(16));
		enter_at(at, {isa_pkg::OP_RTI, 11'h000});
		n = 0;
		while (busy) begin
			n++;
			if (n > 2 * `RTI_CYCLES) begin
				$display("Error: busy never dropped after RTI");
				stop_on_error();
			end
			c = idle_ctl();
			// Busy cycle n runs at count RTI_CYCLES - n + 1.
			if (n == `RTI_CYCLES - 1) c.data_bus = lo;
			if (n == `RTI_CYCLES) c.data_bus = hi;
			cycle(NO_WR, c);
		end
		compare("rti busy cycles", n, `RTI_CYCLES);
		compare("pc", pc, {hi, lo});
	endtask

	task automatic interrupt_case();
		ctl_t c;
		logic [31:0] held;
		logic [31:0] vec;
		int n;
		wait_idle();
		held = pc;
		vec = `INT_VECTOR;
		c = idle_ctl();
		c.interrupt = 1'b1;
		cycle(NO_WR, c);
		compare("instr", 32'(instr), 32'h0);
		compare("instr_valid", 32'(instr_valid), 32'h0);
		compare("pc", pc, held);
		n = 0;
		while (busy) begin
			if (n > 2 * `INT_CYCLES) begin
				$display("Error: busy never dropped after interrupt entry");
				stop_on_error();
			end
			cycle(NO_WR, idle_ctl());
			n++;
		end
		compare("interrupt busy cycles", n, `INT_CYCLES);
		cycle(NO_WR, idle_ctl());
		compare("pc", pc, vec);
		compare("instr", 32'(instr), 32'(m_mem[vec[`IMEM_AW-1:0]]));
	endtask

	initial begin
		#(TEST_CYCLES * 10 + 1000);
		$display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
		stop_on_error();
	end

	initial begin
		fetch_ctrl_pkg::mem_wr_t w;
		ctl_t c;
		lfsr = 16'd9;
		errors = 0;
		rst = 1'b1;
		apply(NO_WR, '0);
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		m_pc = `RESET_PC;
		m_instr = '0;
		m_valid = 1'b0;
		m_state = fetch_ctrl_pkg::SEQ_RUN;
		m_count = 0;
		check_outputs();

		for (int i = 0; i < DEPTH; i++) begin
			write_word(i[`IMEM_AW-1:0], 16'(take_bits(16)));
		end
		repeat (SEQ_LEN) cycle(NO_WR, idle_ctl());

		repeat (JUMP_LEN) begin
			w = NO_WR;
			if (take_bits(3) == 0) begin
				w.en = 1'b1;
				w.addr = take_bits(32);
				w.data = 16'(take_bits(16));
			end
			c = idle_ctl();
			c.jump_taken = take_bits(2) == 0;
			c.jump_target = 16'(take_bits(16));
			c.direct_jump = take_bits(2) == 0;
			c.direct_target = 16'(take_bits(16));
			c.interrupt = take_bits(4) == 0;
			cycle(w, c);
		end

		hazard_case(6'd8, {isa_pkg::OP_LD, 3'd1, 3'd3, 5'd0}, {5'd0, 3'd3, 3'd0, 5'd0});
		hazard_case(6'd16, {isa_pkg::OP_LDX, 3'd5, 3'd2, 5'd0}, {5'd0, 3'd0, 3'd5, 5'd0});
		repeat (2) begin
			call_case(6'd24);
			rti_case(6'd40);
		end
		repeat (2) interrupt_case();

		if (errors == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "errors found");
		end
	end

endmodule
